//--- all.f
design/rv_decode_pkg.sv
design/rv_decode_stage_reg.sv
design/rv_instr_classify.sv
design/rv_imm_gen.sv
design/rv_ctrl_gen.sv
design/rv_decode.sv
sim/rv_decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_decode_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard design/*.sv) $(wildcard sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/rv_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_tb
    import rv_decode_pkg::*;
();

    localparam int clk_period      = 4;
    localparam int reset_cycles    = 8;
    localparam int n_tests         = 6;
    localparam int cycles_per_test = 40;
    localparam int watchdog_ns     = (reset_cycles + n_tests * cycles_per_test) * clk_period;

    localparam logic [2:0] load_f3 [5]  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    localparam logic [2:0] store_f3 [3] = '{3'd0, 3'd1, 3'd2};
    localparam logic [2:0] br_f3 [6]    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    localparam alu_op_e    br_alu [6]   = '{alu_cmp_eq, alu_cmp_neq, alu_cmp_lts,
                                            alu_cmp_nlts, alu_cmp_ltu, alu_cmp_nltu};

    logic        i_clk;
    logic        i_arst_n;
    logic        i_stall;
    logic        i_flush;
    instr_t      i_instr;
    pc_t         i_pc;
    pc_t         i_pc_p4;
    reg_idx_t    o_rs1;
    reg_idx_t    o_rs2;
    reg_idx_t    o_rd;
    funct3_t     o_funct3;
    pc_t         o_pc;
    pc_t         o_pc_p4;
    logic [31:0] o_imm;
    logic        o_reg_write;
    logic        o_mem_read;
    logic        o_mem_write;
    logic        o_jump;
    logic        o_branch;
    logic        o_pc_sel;
    logic        o_inv_instr;
    res_src_e    o_res_src;
    op1_sel_e    o_alu_op1_sel;
    op2_sel_e    o_alu_op2_sel;
    logic [4:0]  o_alu_ctrl;

    logic [31:0] lfsr_state = 32'h59092251;

    rv_decode dut0 (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_pc_p4       (i_pc_p4),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_funct3      (o_funct3),
        .o_pc          (o_pc),
        .o_pc_p4       (o_pc_p4),
        .o_imm         (o_imm),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_inv_instr   (o_inv_instr),
        .o_res_src     (o_res_src),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_alu_ctrl    (o_alu_ctrl)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(clk_period / 2) i_clk = ~i_clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    // one word per cycle, outputs checked just after the next rising edge
    task automatic drive(input instr_t w, input pc_t pc, input logic stall, input logic flush);
        @(negedge i_clk);
        i_instr = w;
        i_pc    = pc;
        i_pc_p4 = pc + 30'd1;
        i_stall = stall;
        i_flush = flush;
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_nop();
        compare("o_mem_read", 32'(o_mem_read), 32'd0);
        compare("o_mem_write", 32'(o_mem_write), 32'd0);
        compare("o_jump", 32'(o_jump), 32'd0);
        compare("o_branch", 32'(o_branch), 32'd0);
        compare("o_pc_sel", 32'(o_pc_sel), 32'd0);
        compare("o_inv_instr", 32'(o_inv_instr), 32'd0);
        compare("o_reg_write", 32'(o_reg_write), 32'd1);
        compare("o_rd", 32'(o_rd), 32'd0);
        compare("o_alu_ctrl", 32'(o_alu_ctrl), 32'(alu_add));
        compare("o_alu_op1_sel", 32'(o_alu_op1_sel), 32'(op1_reg));
        compare("o_alu_op2_sel", 32'(o_alu_op2_sel), 32'(op2_imm));
        compare("o_res_src", 32'(o_res_src), 32'(res_alu));
        compare("o_imm", o_imm, 32'd0);
        compare("o_pc", 32'(o_pc), 32'd0);
        compare("o_pc_p4", 32'(o_pc_p4), 32'd0);
    endtask

    task automatic test_reset_nop();
        logic [31:0] r;
        rand_bits(32, r);
        // stall keeps the reset bubble in place
        drive(r, r[29:0], 1'b1, 1'b0);
        check_nop();
    endtask

    task automatic arith_reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                input logic [4:0] exp_alu);
        logic [31:0] r;
        rand_bits(15, r);
        drive({f7, r[9:5], r[4:0], f3, r[14:10], 7'b0110011}, '0, 1'b0, 1'b0);
        compare("o_alu_ctrl", 32'(o_alu_ctrl), 32'(exp_alu));
        compare("o_alu_op1_sel", 32'(o_alu_op1_sel), 32'(op1_reg));
        compare("o_alu_op2_sel", 32'(o_alu_op2_sel), 32'(op2_reg));
        compare("o_reg_write", 32'(o_reg_write), 32'd1);
        compare("o_rs1", 32'(o_rs1), 32'(r[4:0]));
        compare("o_rs2", 32'(o_rs2), 32'(r[9:5]));
        compare("o_rd", 32'(o_rd), 32'(r[14:10]));
    endtask

    task automatic arith_imm_op(input logic [2:0] f3, input logic use_f7,
                                input logic [6:0] f7, input logic [4:0] exp_alu);
        logic [31:0] r;
        logic [11:0] imm;
        rand_bits(22, r);
        imm = use_f7 ? {f7, r[14:10]} : r[21:10];
        drive({imm, r[4:0], f3, r[9:5], 7'b0010011}, '0, 1'b0, 1'b0);
        compare("o_alu_ctrl", 32'(o_alu_ctrl), 32'(exp_alu));
        compare("o_alu_op1_sel", 32'(o_alu_op1_sel), 32'(op1_reg));
        compare("o_alu_op2_sel", 32'(o_alu_op2_sel), 32'(op2_imm));
        compare("o_reg_write", 32'(o_reg_write), 32'd1);
        compare("o_rs1", 32'(o_rs1), 32'(r[4:0]));
        compare("o_rd", 32'(o_rd), 32'(r[9:5]));
        compare("o_imm", o_imm, {{20{imm[11]}}, imm});
    endtask

    task automatic test_arith();
        arith_reg_op(f7_base, 3'd0, {1'b0, alu_add});
        arith_reg_op(f7_alt,  3'd0, {1'b0, alu_sub});
        arith_reg_op(f7_base, 3'd1, {1'b0, alu_shl});
        arith_reg_op(f7_base, 3'd2, {1'b0, alu_cmp_lts});
        arith_reg_op(f7_base, 3'd3, {1'b0, alu_cmp_ltu});
        arith_reg_op(f7_base, 3'd4, {1'b0, alu_xor});
        arith_reg_op(f7_base, 3'd5, {1'b0, alu_shr});
        arith_reg_op(f7_alt,  3'd5, {1'b1, alu_shr});
        arith_reg_op(f7_base, 3'd6, {1'b0, alu_or});
        arith_reg_op(f7_base, 3'd7, {1'b0, alu_and});
        arith_imm_op(3'd0, 1'b0, f7_base, {1'b0, alu_add});
        arith_imm_op(3'd2, 1'b0, f7_base, {1'b0, alu_cmp_lts});
        arith_imm_op(3'd3, 1'b0, f7_base, {1'b0, alu_cmp_ltu});
        arith_imm_op(3'd4, 1'b0, f7_base, {1'b0, alu_xor});
        arith_imm_op(3'd6, 1'b0, f7_base, {1'b0, alu_or});
        arith_imm_op(3'd7, 1'b0, f7_base, {1'b0, alu_and});
        arith_imm_op(3'd1, 1'b1, f7_base, {1'b0, alu_shl});
        arith_imm_op(3'd5, 1'b1, f7_base, {1'b0, alu_shr});
        arith_imm_op(3'd5, 1'b1, f7_alt,  {1'b1, alu_shr});
    endtask

    task automatic imm_case(input string name, input instr_t w, input logic [31:0] exp);
        drive(w, '0, 1'b0, 1'b0);
        compare(name, o_imm, exp);
    endtask

    // words are built from a chosen immediate, so the expected value is that immediate
    task automatic test_imm_formats();
        logic [31:0] g;
        logic [31:0] v;
        logic [12:0] b;
        logic [20:0] j;
        for (int n = 0; n < 4; n++)
        begin
            rand_bits(15, g);
            rand_bits(20, v);
            imm_case("o_imm (addi)", {v[11:0], g[4:0], 3'b000, g[14:10], 7'b0010011},
                     {{20{v[11]}}, v[11:0]});
            imm_case("o_imm (sw)", {v[11:5], g[9:5], g[4:0], 3'b010, v[4:0], 7'b0100011},
                     {{20{v[11]}}, v[11:0]});
            b = {v[11:0], 1'b0};
            imm_case("o_imm (beq)",
                     {b[12], b[10:5], g[9:5], g[4:0], 3'b000, b[4:1], b[11], 7'b1100011},
                     {{19{b[12]}}, b});
            imm_case("o_imm (lui)", {v[19:0], g[14:10], 7'b0110111}, {v[19:0], 12'h000});
            j = {v[19:0], 1'b0};
            imm_case("o_imm (jal)", {j[20], j[10:1], j[11], j[19:12], g[14:10], 7'b1101111},
                     {{11{j[20]}}, j});
        end
    endtask

    task automatic flow_op(input instr_t w, input logic mem_read, input logic mem_write,
                           input logic jump, input logic branch, input logic pc_sel,
                           input logic reg_write, input res_src_e res, input alu_op_e alu);
        logic [31:0] r;
        pc_t         pc_next;
        rand_bits(30, r);
        pc_next = r[29:0] + 30'd1;
        drive(w, r[29:0], 1'b0, 1'b0);
        compare("o_mem_read", 32'(o_mem_read), 32'(mem_read));
        compare("o_mem_write", 32'(o_mem_write), 32'(mem_write));
        compare("o_jump", 32'(o_jump), 32'(jump));
        compare("o_branch", 32'(o_branch), 32'(branch));
        compare("o_pc_sel", 32'(o_pc_sel), 32'(pc_sel));
        compare("o_reg_write", 32'(o_reg_write), 32'(reg_write));
        compare("o_res_src", 32'(o_res_src), 32'(res));
        compare("o_alu_ctrl", 32'(o_alu_ctrl), 32'(alu));
        compare("o_inv_instr", 32'(o_inv_instr), 32'd0);
        compare("o_funct3", 32'(o_funct3), 32'(w[14:12]));
        compare("o_pc", 32'(o_pc), 32'(r[29:0]));
        compare("o_pc_p4", 32'(o_pc_p4), 32'(pc_next));
    endtask

    task automatic test_flow();
        foreach (load_f3[k])
            flow_op({12'h010, 5'd2, load_f3[k], 5'd5, 7'b0000011},
                    1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, res_memory, alu_add);
        foreach (store_f3[k])
            flow_op({7'h00, 5'd6, 5'd2, store_f3[k], 5'd8, 7'b0100011},
                    1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, res_alu, alu_add);
        foreach (br_f3[k])
            flow_op({7'h00, 5'd4, 5'd3, br_f3[k], 5'd16, 7'b1100011},
                    1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, res_alu, br_alu[k]);
        flow_op({20'h00100, 5'd1, 7'b1101111},
                1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, res_pc_p4, alu_add);
        flow_op({12'h004, 5'd1, 3'b000, 5'd0, 7'b1100111},
                1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, res_pc_p4, alu_add);
    endtask

    task automatic test_stall_flush();
        logic [31:0] r;
        instr_t      wa;
        instr_t      wb;
        pc_t         pca;
        pc_t         pcb;
        pc_t         pca_next;
        reg_idx_t    rd_a;
        reg_idx_t    rd_b;
        rand_bits(30, r);
        pca = r[29:0];
        pcb = ~pca;
        pca_next = pca + 30'd1;
        rand_bits(10, r);
        rd_a = r[4:0];
        rd_b = ~r[4:0];
        wa = {f7_base, 5'd2, 5'd1, 3'b000, rd_a, 7'b0110011};
        wb = {12'h000, 5'd1, 3'b010, rd_b, 7'b0000011};
        drive(wa, pca, 1'b0, 1'b0);
        compare("o_rd", 32'(o_rd), 32'(rd_a));
        repeat (2)
        begin
            drive(wb, pcb, 1'b1, 1'b0);
            compare("o_rd", 32'(o_rd), 32'(rd_a));
            compare("o_mem_read", 32'(o_mem_read), 32'd0);
            compare("o_pc", 32'(o_pc), 32'(pca));
            compare("o_pc_p4", 32'(o_pc_p4), 32'(pca_next));
        end
        drive(wb, pcb, 1'b0, 1'b0);
        compare("o_rd", 32'(o_rd), 32'(rd_b));
        compare("o_mem_read", 32'(o_mem_read), 32'd1);
        compare("o_pc", 32'(o_pc), 32'(pcb));
        drive(wa, pca, 1'b0, 1'b1);
        check_nop();
        drive(wb, pcb, 1'b0, 1'b0);
        compare("o_mem_read", 32'(o_mem_read), 32'd1);
        // flush has priority over a stall in the same cycle
        drive(wa, pca, 1'b1, 1'b1);
        check_nop();
    endtask

    task automatic illegal_case(input instr_t w);
        drive(w, '0, 1'b0, 1'b0);
        compare("o_inv_instr", 32'(o_inv_instr), 32'd1);
        compare("o_imm", o_imm, 32'd0);
        compare("o_mem_read", 32'(o_mem_read), 32'd0);
        compare("o_mem_write", 32'(o_mem_write), 32'd0);
        compare("o_jump", 32'(o_jump), 32'd0);
        compare("o_branch", 32'(o_branch), 32'd0);
        compare("o_pc_sel", 32'(o_pc_sel), 32'd0);
    endtask

    task automatic test_illegal();
        logic [31:0] r;
        rand_bits(30, r);
        illegal_case({r[29:0], 2'b01});
        illegal_case({7'b000_0001, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011});
        illegal_case(32'h0000_0073);
    endtask

    initial
    begin
        #(watchdog_ns);
        stop_with_failure("timeout: the tests did not finish in time");
    end

    initial
    begin
        i_arst_n = 1'b0;
        i_stall  = 1'b0;
        i_flush  = 1'b0;
        i_instr  = nop_instr;
        i_pc     = '0;
        i_pc_p4  = '0;
        repeat (reset_cycles) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;
        test_reset_nop();
        test_arith();
        test_imm_formats();
        test_flow();
        test_stall_flush();
        test_illegal();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_decode_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_arst_n,
    input  wire logic   i_stall,
    input  wire logic   i_flush,
    input  wire instr_t i_instr,
    input  wire pc_t    i_pc,
    input  wire pc_t    i_pc_p4,
    output reg_idx_t    o_rs1,
    output reg_idx_t    o_rs2,
    output reg_idx_t    o_rd,
    output funct3_t     o_funct3,
    output pc_t         o_pc,
    output pc_t         o_pc_p4,
    output logic [xlen-1:0] o_imm,
    output logic        o_reg_write,
    output logic        o_mem_read,
    output logic        o_mem_write,
    output logic        o_jump,
    output logic        o_branch,
    output logic        o_pc_sel,
    output logic        o_inv_instr,
    output res_src_e    o_res_src,
    output op1_sel_e    o_alu_op1_sel,
    output op2_sel_e    o_alu_op2_sel,
    output logic [4:0]  o_alu_ctrl
);

    instr_t      instr_q;
    instr_kind_e kind;
    imm_fmt_e    imm_fmt;

    rv_decode_stage_reg u_stage_reg (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_stall  (i_stall),
        .i_flush  (i_flush),
        .i_instr  (i_instr),
        .i_pc     (i_pc),
        .i_pc_p4  (i_pc_p4),
        .o_instr  (instr_q),
        .o_pc     (o_pc),
        .o_pc_p4  (o_pc_p4)
    );

    rv_instr_classify u_classify (
        .i_instr     (instr_q),
        .o_kind      (kind),
        .o_imm_fmt   (imm_fmt),
        .o_inv_instr (o_inv_instr)
    );

    rv_imm_gen u_imm_gen (
        .i_instr (instr_q),
        .i_fmt   (imm_fmt),
        .o_imm   (o_imm)
    );

    rv_ctrl_gen u_ctrl_gen (
        .i_kind        (kind),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_res_src     (o_res_src),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_alu_ctrl    (o_alu_ctrl)
    );

    // raw fields, valid whatever the format
    assign o_rd     = instr_q[11:7];
    assign o_funct3 = instr_q[14:12];
    assign o_rs1    = instr_q[19:15];
    assign o_rs2    = instr_q[24:20];

endmodule

`default_nettype wire

//--- design/rv_ctrl_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_gen
    import rv_decode_pkg::*;
(
    input  wire instr_kind_e i_kind,
    output logic        o_reg_write,
    output logic        o_mem_read,
    output logic        o_mem_write,
    output logic        o_jump,
    output logic        o_branch,
    output logic        o_pc_sel,
    output res_src_e    o_res_src,
    output op1_sel_e    o_alu_op1_sel,
    output op2_sel_e    o_alu_op2_sel,
    output logic [4:0]  o_alu_ctrl
);

    logic    is_load;
    logic    is_store;
    logic    is_imm;
    logic    is_reg;
    logic    is_jump;
    alu_op_e alu_op;

    assign is_load  = i_kind inside {kind_lb, kind_lh, kind_lw, kind_lbu, kind_lhu};
    assign is_store = i_kind inside {kind_sb, kind_sh, kind_sw};
    assign is_imm   = i_kind inside {kind_addi, kind_slli, kind_slti, kind_sltiu, kind_xori,
                                     kind_srli, kind_srai, kind_ori, kind_andi};
    assign is_reg   = i_kind inside {kind_add, kind_sub, kind_sll, kind_slt, kind_sltu,
                                     kind_xor, kind_srl, kind_sra, kind_or, kind_and};
    assign is_jump  = i_kind inside {kind_jal, kind_jalr};

    assign o_branch = i_kind inside {kind_beq, kind_bne, kind_blt, kind_bge,
                                     kind_bltu, kind_bgeu};

    assign o_reg_write = is_load | is_imm | is_reg | is_jump
                       | (i_kind == kind_lui) | (i_kind == kind_auipc);
    assign o_mem_read  = is_load;
    assign o_mem_write = is_store;
    assign o_jump      = is_jump;
    assign o_pc_sel    = (i_kind == kind_jalr);

    // lui goes through the alu as 0 + imm
    assign o_alu_op1_sel = (i_kind inside {kind_auipc, kind_jal}) ? op1_pc :
                           (i_kind == kind_lui)                  ? op1_zero : op1_reg;

    assign o_alu_op2_sel = (is_imm | is_load | is_store | is_jump
                         | (i_kind == kind_lui) | (i_kind == kind_auipc)) ? op2_imm : op2_reg;

    assign o_res_src = is_load ? res_memory :
                       is_jump ? res_pc_p4  : res_alu;

    always_comb
    begin
        case (i_kind)
            kind_beq:                          alu_op = alu_cmp_eq;
            kind_bne:                          alu_op = alu_cmp_neq;
            kind_slt, kind_slti, kind_blt:     alu_op = alu_cmp_lts;
            kind_bge:                          alu_op = alu_cmp_nlts;
            kind_sltu, kind_sltiu, kind_bltu:  alu_op = alu_cmp_ltu;
            kind_bgeu:                         alu_op = alu_cmp_nltu;
            kind_sub:                          alu_op = alu_sub;
            kind_xor, kind_xori:               alu_op = alu_xor;
            kind_or, kind_ori:                 alu_op = alu_or;
            kind_and, kind_andi:               alu_op = alu_and;
            kind_sll, kind_slli:               alu_op = alu_shl;
            kind_srl, kind_srli,
            kind_sra, kind_srai:               alu_op = alu_shr;
            default:                           alu_op = alu_add;
        endcase
        // bit 4 picks arithmetic shift
        o_alu_ctrl = {(i_kind inside {kind_sra, kind_srai}), alu_op};
        a_mem_excl: assert final (!(o_mem_read && o_mem_write));
    end

endmodule

`default_nettype wire

//--- design/rv_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen
    import rv_decode_pkg::*;
(
    input  wire instr_t   i_instr,
    input  wire imm_fmt_e i_fmt,
    output logic [xlen-1:0] o_imm
);

    logic sign;

    assign sign = i_instr[31];

    always_comb
    begin
        case (i_fmt)
            imm_i:
                o_imm = {{21{sign}}, i_instr[30:20]};
            imm_s:
                o_imm = {{21{sign}}, i_instr[30:25], i_instr[11:7]};
            imm_b:
                o_imm = {{20{sign}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
            imm_u:
                o_imm = {i_instr[31:12], 12'h000};
            imm_j:
                o_imm = {{12{sign}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
            // no immediate, keep it quiet
            default:
                o_imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_instr_classify.sv
`timescale 1ns/1ps
`default_nettype none

module rv_instr_classify
    import rv_decode_pkg::*;
(
    input  wire instr_t i_instr,
    output instr_kind_e o_kind,
    output imm_fmt_e    o_imm_fmt,
    output logic        o_inv_instr
);

    op_grp_e    grp;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // compressed encodings never reach a group
    always_comb
    begin
        grp = grp_none;
        if (i_instr[1:0] == 2'b11)
        begin
            case (i_instr[6:2])
                5'b00000: grp = grp_load;
                5'b00011: grp = grp_misc_mem;
                5'b00100: grp = grp_arith_imm;
                5'b00101: grp = grp_auipc;
                5'b01000: grp = grp_store;
                5'b01100: grp = grp_arith_reg;
                5'b01101: grp = grp_lui;
                5'b11000: grp = grp_branch;
                5'b11001: grp = grp_jalr;
                5'b11011: grp = grp_jal;
                5'b11100: grp = grp_system;
                default:  grp = grp_none;
            endcase
        end
    end

    always_comb
    begin
        o_kind = kind_illegal;
        case (grp)
            grp_load:
            begin
                case (funct3)
                    3'b000:  o_kind = kind_lb;
                    3'b001:  o_kind = kind_lh;
                    3'b010:  o_kind = kind_lw;
                    3'b100:  o_kind = kind_lbu;
                    3'b101:  o_kind = kind_lhu;
                    default: o_kind = kind_illegal;
                endcase
            end
            grp_misc_mem:
            begin
                if (funct3 == 3'b000)
                    o_kind = kind_fence;
                else if (funct3 == 3'b001)
                    o_kind = kind_fence_i;
            end
            grp_arith_imm:
            begin
                case (funct3)
                    3'b000: o_kind = kind_addi;
                    3'b001: o_kind = kind_slli;
                    3'b010: o_kind = kind_slti;
                    3'b011: o_kind = kind_sltiu;
                    3'b100: o_kind = kind_xori;
                    3'b101:
                    begin
                        if (funct7 == f7_base)
                            o_kind = kind_srli;
                        else if (funct7 == f7_alt)
                            o_kind = kind_srai;
                    end
                    3'b110: o_kind = kind_ori;
                    3'b111: o_kind = kind_andi;
                    default: o_kind = kind_illegal;
                endcase
            end
            grp_auipc: o_kind = kind_auipc;
            grp_store:
            begin
                case (funct3)
                    3'b000:  o_kind = kind_sb;
                    3'b001:  o_kind = kind_sh;
                    3'b010:  o_kind = kind_sw;
                    default: o_kind = kind_illegal;
                endcase
            end
            grp_arith_reg:
            begin
                if (funct7 == f7_base)
                begin
                    case (funct3)
                        3'b000:  o_kind = kind_add;
                        3'b001:  o_kind = kind_sll;
                        3'b010:  o_kind = kind_slt;
                        3'b011:  o_kind = kind_sltu;
                        3'b100:  o_kind = kind_xor;
                        3'b101:  o_kind = kind_srl;
                        3'b110:  o_kind = kind_or;
                        default: o_kind = kind_and;
                    endcase
                end
                else if (funct7 == f7_alt)
                begin
                    if (funct3 == 3'b000)
                        o_kind = kind_sub;
                    else if (funct3 == 3'b101)
                        o_kind = kind_sra;
                end
            end
            grp_lui: o_kind = kind_lui;
            grp_branch:
            begin
                case (funct3)
                    3'b000:  o_kind = kind_beq;
                    3'b001:  o_kind = kind_bne;
                    3'b100:  o_kind = kind_blt;
                    3'b101:  o_kind = kind_bge;
                    3'b110:  o_kind = kind_bltu;
                    3'b111:  o_kind = kind_bgeu;
                    default: o_kind = kind_illegal;
                endcase
            end
            grp_jalr:
            begin
                if (funct3 == 3'b000)
                    o_kind = kind_jalr;
            end
            grp_jal: o_kind = kind_jal;
            // ecall and ebreak not supported
            grp_system: o_kind = kind_illegal;
            default: o_kind = kind_illegal;
        endcase
    end

    always_comb
    begin
        case (o_kind)
            kind_jal:
                o_imm_fmt = imm_j;
            kind_lui, kind_auipc:
                o_imm_fmt = imm_u;
            kind_jalr, kind_lb, kind_lh, kind_lw, kind_lbu, kind_lhu,
            kind_addi, kind_slli, kind_slti, kind_sltiu, kind_xori,
            kind_srli, kind_srai, kind_ori, kind_andi:
                o_imm_fmt = imm_i;
            kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu:
                o_imm_fmt = imm_b;
            kind_sb, kind_sh, kind_sw:
                o_imm_fmt = imm_s;
            default:
                o_imm_fmt = imm_none;
        endcase
        o_inv_instr = (o_kind == kind_illegal);
        a_inv_no_imm: assert final (!o_inv_instr || o_imm_fmt == imm_none);
    end

endmodule

`default_nettype wire

//--- design/rv_decode_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage_reg
    import rv_decode_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_arst_n,
    input  wire logic   i_stall,
    input  wire logic   i_flush,
    input  wire instr_t i_instr,
    input  wire pc_t    i_pc,
    input  wire pc_t    i_pc_p4,
    output instr_t      o_instr,
    output pc_t         o_pc,
    output pc_t         o_pc_p4
);

    // flush beats stall, bubble is a real nop
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_instr <= nop_instr;
            o_pc    <= '0;
            o_pc_p4 <= '0;
        end
        else if (i_flush)
        begin
            o_instr <= nop_instr;
            o_pc    <= '0;
            o_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            o_instr <= i_instr;
            o_pc    <= i_pc;
            o_pc_p4 <= i_pc_p4;
        end
    end

    a_stall_hold: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (i_stall && !i_flush) |=>
            ($stable(o_instr) && $stable(o_pc) && $stable(o_pc_p4))
    );

endmodule

`default_nettype wire

//--- design/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    localparam int xlen = 32;

    typedef logic [31:0] instr_t;
    // word address, byte offset dropped
    typedef logic [31:2] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // addi x0, x0, 0
    localparam instr_t nop_instr = 32'h0000_0013;

    localparam logic [6:0] f7_base = 7'b000_0000;
    localparam logic [6:0] f7_alt  = 7'b010_0000;

    typedef enum logic [3:0] {
        grp_none,
        grp_load,
        grp_misc_mem,
        grp_arith_imm,
        grp_auipc,
        grp_store,
        grp_arith_reg,
        grp_lui,
        grp_branch,
        grp_jalr,
        grp_jal,
        grp_system
    } op_grp_e;

    typedef enum logic [5:0] {
        kind_lb, kind_lh, kind_lw, kind_lbu, kind_lhu,
        kind_addi, kind_slli, kind_slti, kind_sltiu, kind_xori,
        kind_srli, kind_srai, kind_ori, kind_andi,
        kind_auipc,
        kind_sb, kind_sh, kind_sw,
        kind_add, kind_sub, kind_sll, kind_slt, kind_sltu,
        kind_xor, kind_srl, kind_sra, kind_or, kind_and,
        kind_lui,
        kind_beq, kind_bne, kind_blt, kind_bge, kind_bltu, kind_bgeu,
        kind_jalr,
        kind_jal,
        kind_fence,
        kind_fence_i,
        kind_illegal
    } instr_kind_e;

    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_e;

    // bit 3 marks the compare codes
    typedef enum logic [3:0] {
        alu_add      = 4'd0,
        alu_sub      = 4'd1,
        alu_xor      = 4'd2,
        alu_or       = 4'd3,
        alu_and      = 4'd4,
        alu_shl      = 4'd5,
        alu_shr      = 4'd6,
        alu_cmp_eq   = 4'd8,
        alu_cmp_neq  = 4'd9,
        alu_cmp_lts  = 4'd10,
        alu_cmp_nlts = 4'd11,
        alu_cmp_ltu  = 4'd12,
        alu_cmp_nltu = 4'd13
    } alu_op_e;

    typedef enum logic [1:0] {
        op1_reg  = 2'd0,
        op1_pc   = 2'd1,
        op1_zero = 2'd2
    } op1_sel_e;

    typedef enum logic {
        op2_reg = 1'b0,
        op2_imm = 1'b1
    } op2_sel_e;

    typedef enum logic [1:0] {
        res_alu    = 2'd0,
        res_memory = 2'd1,
        res_pc_p4  = 2'd2
    } res_src_e;

endpackage

`default_nettype wire
